/* include/vfu_params.svh */
/*
  Width and count macros of the vector functional unit.
  Included by the package and by every module that sizes logic from them.
*/
`ifndef VFU_PARAMS_SVH
`define VFU_PARAMS_SVH

// Lane and word geometry
`define VFU_ELEN 32
`define VFU_N_LANES 2
`define VFU_WORD_W 64
`define VFU_WORD_BYTES 8
`define VFU_WORDS_PER_VREG 4

// VRF addressing, vector length and instruction id
`define VFU_VADDR_W 7
`define VFU_VL_W 6
`define VFU_ID_W 2

`endif

/* design/vfu_pkg.sv */
/*
  Shared types of the vector functional unit: op and element width
  encodings, the VRF word union and the small width types.
  Imported by wildcard in every module header.
*/
`include "vfu_params.svh"

package vfu_pkg;

  // Integer operations kept in the unit
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MIN = 3'd5,
    OP_MAX = 3'd6,
    OP_SLL = 3'd7
  } vfu_op_e;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  // One VRF word, decoded per element width
  typedef union packed {
    logic [`VFU_WORD_BYTES-1:0][7:0]          b;
    logic [`VFU_WORD_W/16-1:0][15:0]          h;
    logic [`VFU_N_LANES-1:0][`VFU_ELEN-1:0]   w;
  } vfu_word_u;

  typedef logic [`VFU_VADDR_W-1:0]    vaddr_t;
  typedef logic [`VFU_VL_W-1:0]       vl_t;
  typedef logic [`VFU_ID_W-1:0]       vfu_id_t;
  typedef logic [`VFU_WORD_BYTES-1:0] vbe_t;

endpackage

/* design/vfu_req_queue.sv */
/*
  Two-entry instruction queue in front of the sequencer.
  Lets the next instruction be accepted while the current one is still
  being walked through the VRF; the sequencer pops on its last word.
*/
module vfu_req_queue import vfu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  vfu_id_t     req_id_i,
  input  vfu_op_e     req_op_i,
  input  vew_e        req_vsew_i,
  input  vl_t         req_vl_i,
  input  vl_t         req_vstart_i,
  input  logic [4:0]  req_vs1_i,
  input  logic [4:0]  req_vs2_i,
  input  logic [4:0]  req_vd_i,
  input  logic        req_use_vs1_i,
  input  logic [31:0] req_rs1_i,
  input  logic        pop_i,
  output logic        valid_o,
  output vfu_id_t     id_o,
  output vfu_op_e     op_o,
  output vew_e        vsew_o,
  output vl_t         vl_o,
  output vl_t         vstart_o,
  output logic [4:0]  vs1_o,
  output logic [4:0]  vs2_o,
  output logic [4:0]  vd_o,
  output logic        use_vs1_o,
  output logic [31:0] rs1_o
);

  localparam int unsigned EntryW = $bits(vfu_id_t) + $bits(vfu_op_e) + $bits(vew_e) +
                                   2 * $bits(vl_t) + 3 * 5 + 1 + 32;

  logic [EntryW-1:0] mem_q [2];
  logic [EntryW-1:0] din;
  logic [EntryW-1:0] dout;
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [1:0]        cnt_q;
  logic              push;
  logic [2:0]        op_bits;
  logic [1:0]        vsew_bits;

  assign req_ready_o = (cnt_q != 2'd2);
  assign valid_o     = (cnt_q != 2'd0);
  assign push        = req_valid_i && req_ready_o;

  assign din  = {req_id_i, req_op_i, req_vsew_i, req_vl_i, req_vstart_i,
                 req_vs1_i, req_vs2_i, req_vd_i, req_use_vs1_i, req_rs1_i};
  assign dout = mem_q[rd_ptr_q];
  assign {id_o, op_bits, vsew_bits, vl_o, vstart_o,
          vs1_o, vs2_o, vd_o, use_vs1_o, rs1_o} = dout;
  assign op_o   = vfu_op_e'(op_bits);
  assign vsew_o = vew_e'(vsew_bits);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop_i) rd_ptr_q <= ~rd_ptr_q;
      cnt_q <= cnt_q + 2'(push) - 2'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= din;
  end

  // The sequencer only retires an instruction it has been shown
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> valid_o);

endmodule

/* design/vfu_sequencer.sv */
/*
  Walks the queued instruction word by word through the VRF.
  Drives the read ports, issues one word per cycle into the operand
  stage together with its tag, and pops the queue on the last word.
*/
`include "vfu_params.svh"

module vfu_sequencer import vfu_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         valid_i,
  input  vfu_id_t      id_i,
  input  vfu_op_e      op_i,
  input  vew_e         vsew_i,
  input  vl_t          vl_i,
  input  vl_t          vstart_i,
  input  logic [4:0]   vs1_i,
  input  logic [4:0]   vs2_i,
  input  logic [4:0]   vd_i,
  input  logic         use_vs1_i,
  input  logic [1:0]   vrf_rvalid_i,
  input  logic         op_ready_i,
  output logic         pop_o,
  output logic [1:0]   vrf_re_o,
  output vaddr_t [1:0] vrf_raddr_o,
  output logic         issue_o,
  output vfu_id_t      id_o,
  output vfu_op_e      op_o,
  output vew_e         vsew_o,
  output vl_t          elem_base_o,
  output vl_t          vstart_o,
  output vl_t          vl_o,
  output logic         last_o,
  output vaddr_t       waddr_o
);

  logic       active_q;
  vl_t        cnt_q;
  vl_t        cur_cnt;
  vl_t        next_cnt;
  vl_t        vstart_base;
  vl_t        word_idx;
  logic [3:0] elems_per_word;
  logic [1:0] word_shift;
  logic       operands_ok;

  ////////////////////////////////////////
  // Element counter
  ////////////////////////////////////////

  assign elems_per_word = 4'd8 >> vsew_i;
  // log2 of elements per word
  assign word_shift     = 2'd3 - vsew_i;
  assign vstart_base    = (vstart_i >> word_shift) << word_shift;

  // First word of a new instruction starts at the word holding vstart
  assign cur_cnt  = active_q ? cnt_q : vstart_base;
  assign next_cnt = cur_cnt + vl_t'(elems_per_word);
  assign word_idx = cur_cnt >> word_shift;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (issue_o) begin
      active_q <= !last_o;
      cnt_q    <= next_cnt;
    end
  end

  ////////////////////////////////////////
  // VRF reads and word issue
  ////////////////////////////////////////

  assign vrf_re_o       = valid_i ? {use_vs1_i, 1'b1} : 2'b00;
  assign vrf_raddr_o[0] = vaddr_t'(vs2_i) * vaddr_t'(`VFU_WORDS_PER_VREG) + vaddr_t'(word_idx);
  assign vrf_raddr_o[1] = vaddr_t'(vs1_i) * vaddr_t'(`VFU_WORDS_PER_VREG) + vaddr_t'(word_idx);

  assign operands_ok = vrf_rvalid_i[0] && (!use_vs1_i || vrf_rvalid_i[1]);
  assign issue_o     = valid_i && operands_ok && op_ready_i;
  assign pop_o       = issue_o && last_o;

  // Tag travelling with the word
  assign id_o        = id_i;
  assign op_o        = op_i;
  assign vsew_o      = vsew_i;
  assign elem_base_o = cur_cnt;
  assign vstart_o    = vstart_i;
  assign vl_o        = vl_i;
  assign last_o      = (next_cnt >= vl_i);
  assign waddr_o     = vaddr_t'(vd_i) * vaddr_t'(`VFU_WORDS_PER_VREG) + vaddr_t'(word_idx);

  // A stalled read holds its request until every requested port answers
  a_read_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && !issue_o) |=> ($stable(vrf_re_o) && $stable(vrf_raddr_o)));

endmodule

/* design/vfu_operand_stage.sv */
/*
  Operand register between the sequencer and the ALU.
  Operand a is the vs2 word; operand b is the vs1 word or the scalar rs1
  replicated across the word at the element width.
*/
module vfu_operand_stage import vfu_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            issue_i,
  input  vfu_id_t         id_i,
  input  vfu_op_e         op_i,
  input  vew_e            vsew_i,
  input  vl_t             elem_base_i,
  input  vl_t             vstart_i,
  input  vl_t             vl_i,
  input  logic            last_i,
  input  vaddr_t          waddr_i,
  input  logic            use_vs1_i,
  input  logic [31:0]     rs1_i,
  input  vfu_word_u [1:0] vrf_rdata_i,
  input  logic            ready_i,
  output logic            op_ready_o,
  output logic            valid_o,
  output vfu_word_u       opa_o,
  output vfu_word_u       opb_o,
  output vfu_id_t         id_o,
  output vfu_op_e         op_o,
  output vew_e            vsew_o,
  output vl_t             elem_base_o,
  output vl_t             vstart_o,
  output vl_t             vl_o,
  output logic            last_o,
  output vaddr_t          waddr_o
);

  vfu_word_u scalar;

  // Replicate the scalar through the view of the element width
  always_comb begin
    scalar = '0;
    unique case (vsew_i)
      EW_8:    scalar.b = {$bits(vfu_word_u)/8{rs1_i[7:0]}};
      EW_16:   scalar.h = {$bits(vfu_word_u)/16{rs1_i[15:0]}};
      default: scalar.w = {$bits(vfu_word_u)/32{rs1_i}};
    endcase
  end

  assign op_ready_o = !valid_o || ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (issue_i) begin
      valid_o <= 1'b1;
    end else if (ready_i) begin
      valid_o <= 1'b0;
    end
  end

  // Payload only moves on issue, so it holds while valid waits
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      opa_o       <= vrf_rdata_i[0];
      opb_o       <= use_vs1_i ? vrf_rdata_i[1] : scalar;
      id_o        <= id_i;
      op_o        <= op_i;
      vsew_o      <= vsew_i;
      elem_base_o <= elem_base_i;
      vstart_o    <= vstart_i;
      vl_o        <= vl_i;
      last_o      <= last_i;
      waddr_o     <= waddr_i;
    end
  end

endmodule

/* design/vfu_alu.sv */
/*
  Lane-parallel integer ALU. Every element of the selected width is
  computed at once through the word union and the result is registered.
*/
`include "vfu_params.svh"

module vfu_alu import vfu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  vfu_word_u opa_i,
  input  vfu_word_u opb_i,
  input  vfu_op_e   op_i,
  input  vew_e      vsew_i,
  input  vfu_id_t   id_i,
  input  vl_t       elem_base_i,
  input  vl_t       vstart_i,
  input  vl_t       vl_i,
  input  logic      last_i,
  input  vaddr_t    waddr_i,
  input  logic      ready_i,
  output logic      ready_o,
  output logic      valid_o,
  output vfu_word_u result_o,
  output vfu_id_t   id_o,
  output vew_e      vsew_o,
  output vl_t       elem_base_o,
  output vl_t       vstart_o,
  output vl_t       vl_o,
  output logic      last_o,
  output vaddr_t    waddr_o
);

  vfu_word_u result;
  logic      load;

  // Operands arrive sign-extended to 32 bits, caller truncates the result
  function automatic logic [31:0] elem_op(vfu_op_e op, logic [31:0] a, logic [31:0] b,
                                          logic [4:0] shamt);
    unique case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      OP_MAX:  return ($signed(a) < $signed(b)) ? b : a;
      default: return a << shamt;
    endcase
  endfunction

  always_comb begin
    result = '0;
    unique case (vsew_i)
      EW_8: begin
        for (int i = 0; i < `VFU_WORD_BYTES; i++) begin
          result.b[i] = 8'(elem_op(op_i, 32'($signed(opa_i.b[i])),
                                   32'($signed(opb_i.b[i])), {2'b00, opb_i.b[i][2:0]}));
        end
      end
      EW_16: begin
        for (int i = 0; i < `VFU_WORD_W / 16; i++) begin
          result.h[i] = 16'(elem_op(op_i, 32'($signed(opa_i.h[i])),
                                    32'($signed(opb_i.h[i])), {1'b0, opb_i.h[i][3:0]}));
        end
      end
      default: begin
        for (int i = 0; i < `VFU_N_LANES; i++) begin
          result.w[i] = elem_op(op_i, opa_i.w[i], opb_i.w[i], opb_i.w[i][4:0]);
        end
      end
    endcase
  end

  assign ready_o = !valid_o || ready_i;
  assign load    = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (load) begin
      valid_o <= 1'b1;
    end else if (ready_i) begin
      valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_o    <= result;
      id_o        <= id_i;
      vsew_o      <= vsew_i;
      elem_base_o <= elem_base_i;
      vstart_o    <= vstart_i;
      vl_o        <= vl_i;
      last_o      <= last_i;
      waddr_o     <= waddr_i;
    end
  end

endmodule

/* design/vfu_writeback.sv */
/*
  Writes ALU results into the VRF with per-byte enables limited to the
  elements in [vstart, vl). On the last word the completion response
  goes out with the write and both finish in the same cycle.
*/
`include "vfu_params.svh"

module vfu_writeback import vfu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  vfu_word_u result_i,
  input  vew_e      vsew_i,
  input  vl_t       elem_base_i,
  input  vl_t       vstart_i,
  input  vl_t       vl_i,
  input  logic      last_i,
  input  vfu_id_t   id_i,
  input  vaddr_t    waddr_i,
  input  logic      vrf_wvalid_i,
  input  logic      vfu_rsp_ready_i,
  output logic      ready_o,
  output logic      vrf_we_o,
  output vaddr_t    vrf_waddr_o,
  output vfu_word_u vrf_wdata_o,
  output vbe_t      vrf_wbe_o,
  output logic      vfu_rsp_valid_o,
  output vfu_id_t   vfu_rsp_id_o
);

  vl_t elem;

  // Element index of each byte, compared against the active range
  always_comb begin
    vrf_wbe_o = '0;
    for (int i = 0; i < `VFU_WORD_BYTES; i++) begin
      elem         = elem_base_i + vl_t'(i >> vsew_i);
      vrf_wbe_o[i] = (elem >= vstart_i) && (elem < vl_i);
    end
  end

  assign vrf_we_o    = valid_i;
  assign vrf_waddr_o = waddr_i;
  assign vrf_wdata_o = result_i;

  assign vfu_rsp_valid_o = valid_i && last_i;
  assign vfu_rsp_id_o    = id_i;

  // Last word waits for both sides
  assign ready_o = vrf_wvalid_i && (!last_i || vfu_rsp_ready_i);

  a_we_has_bytes: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vrf_we_o |-> (vrf_wbe_o != '0));

endmodule

/* design/vfu_top.sv */
/*
  Vector functional unit, integer datapath.
  Pipeline: request queue, sequencer, operand stage, ALU, writeback.
*/
module vfu_top import vfu_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // Instruction request
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  vfu_id_t         req_id_i,
  input  vfu_op_e         req_op_i,
  input  vew_e            req_vsew_i,
  input  vl_t             req_vl_i,
  input  vl_t             req_vstart_i,
  input  logic [4:0]      req_vs1_i,
  input  logic [4:0]      req_vs2_i,
  input  logic [4:0]      req_vd_i,
  input  logic            req_use_vs1_i,
  input  logic [31:0]     req_rs1_i,
  // VRF read ports, 0 is vs2 and 1 is vs1
  output logic [1:0]      vrf_re_o,
  output vaddr_t [1:0]    vrf_raddr_o,
  input  logic [1:0]      vrf_rvalid_i,
  input  vfu_word_u [1:0] vrf_rdata_i,
  // VRF write port
  output logic            vrf_we_o,
  output vaddr_t          vrf_waddr_o,
  output vfu_word_u       vrf_wdata_o,
  output vbe_t            vrf_wbe_o,
  input  logic            vrf_wvalid_i,
  // Completion
  output logic            vfu_rsp_valid_o,
  input  logic            vfu_rsp_ready_i,
  output vfu_id_t         vfu_rsp_id_o
);

  // Queue to sequencer
  logic        q_valid, q_pop, q_use_vs1;
  vfu_id_t     q_id;
  vfu_op_e     q_op;
  vew_e        q_vsew;
  vl_t         q_vl, q_vstart;
  logic [4:0]  q_vs1, q_vs2, q_vd;
  logic [31:0] q_rs1;

  // Sequencer to operand stage
  logic    s_issue, s_last, op_ready;
  vfu_id_t s_id;
  vfu_op_e s_op;
  vew_e    s_vsew;
  vl_t     s_elem_base, s_vstart, s_vl;
  vaddr_t  s_waddr;

  // Operand stage to ALU
  logic      o_valid, o_last, alu_ready;
  vfu_word_u o_opa, o_opb;
  vfu_id_t   o_id;
  vfu_op_e   o_op;
  vew_e      o_vsew;
  vl_t       o_elem_base, o_vstart, o_vl;
  vaddr_t    o_waddr;

  // ALU to writeback
  logic      a_valid, a_last, wb_ready;
  vfu_word_u a_result;
  vfu_id_t   a_id;
  vew_e      a_vsew;
  vl_t       a_elem_base, a_vstart, a_vl;
  vaddr_t    a_waddr;

  vfu_req_queue vfu_req_queue_inst (
    .clk_i, .rst_n_i, .req_valid_i, .req_ready_o, .req_id_i, .req_op_i, .req_vsew_i,
    .req_vl_i, .req_vstart_i, .req_vs1_i, .req_vs2_i, .req_vd_i, .req_use_vs1_i,
    .req_rs1_i,
    .pop_i    (q_pop),    .valid_o  (q_valid),  .id_o   (q_id),   .op_o   (q_op),
    .vsew_o   (q_vsew),   .vl_o     (q_vl),     .vstart_o(q_vstart),
    .vs1_o    (q_vs1),    .vs2_o    (q_vs2),    .vd_o   (q_vd),
    .use_vs1_o(q_use_vs1), .rs1_o   (q_rs1)
  );

  vfu_sequencer vfu_sequencer_inst (
    .clk_i, .rst_n_i,
    .valid_i (q_valid), .id_i  (q_id),  .op_i  (q_op),  .vsew_i   (q_vsew),
    .vl_i    (q_vl),    .vstart_i(q_vstart), .vs1_i(q_vs1), .vs2_i(q_vs2),
    .vd_i    (q_vd),    .use_vs1_i(q_use_vs1), .vrf_rvalid_i, .op_ready_i(op_ready),
    .pop_o   (q_pop),   .vrf_re_o, .vrf_raddr_o, .issue_o(s_issue),
    .id_o    (s_id),    .op_o  (s_op),  .vsew_o(s_vsew), .elem_base_o(s_elem_base),
    .vstart_o(s_vstart), .vl_o (s_vl),  .last_o(s_last), .waddr_o    (s_waddr)
  );

  vfu_operand_stage vfu_operand_stage_inst (
    .clk_i, .rst_n_i,
    .issue_i (s_issue),  .id_i  (s_id),  .op_i  (s_op),  .vsew_i     (s_vsew),
    .elem_base_i(s_elem_base), .vstart_i(s_vstart), .vl_i(s_vl), .last_i(s_last),
    .waddr_i (s_waddr),  .use_vs1_i(q_use_vs1), .rs1_i(q_rs1), .vrf_rdata_i,
    .ready_i (alu_ready), .op_ready_o(op_ready), .valid_o(o_valid),
    .opa_o   (o_opa),    .opb_o (o_opb), .id_o  (o_id),  .op_o       (o_op),
    .vsew_o  (o_vsew),   .elem_base_o(o_elem_base), .vstart_o(o_vstart),
    .vl_o    (o_vl),     .last_o(o_last), .waddr_o(o_waddr)
  );

  vfu_alu vfu_alu_inst (
    .clk_i, .rst_n_i,
    .valid_i (o_valid),  .opa_i (o_opa), .opb_i (o_opb), .op_i (o_op), .vsew_i(o_vsew),
    .id_i    (o_id),     .elem_base_i(o_elem_base), .vstart_i(o_vstart), .vl_i(o_vl),
    .last_i  (o_last),   .waddr_i(o_waddr), .ready_i(wb_ready), .ready_o(alu_ready),
    .valid_o (a_valid),  .result_o(a_result), .id_o(a_id), .vsew_o(a_vsew),
    .elem_base_o(a_elem_base), .vstart_o(a_vstart), .vl_o(a_vl), .last_o(a_last),
    .waddr_o (a_waddr)
  );

  vfu_writeback vfu_writeback_inst (
    .clk_i, .rst_n_i,
    .valid_i (a_valid),  .result_i(a_result), .vsew_i(a_vsew),
    .elem_base_i(a_elem_base), .vstart_i(a_vstart), .vl_i(a_vl), .last_i(a_last),
    .id_i    (a_id),     .waddr_i(a_waddr), .vrf_wvalid_i, .vfu_rsp_ready_i,
    .ready_o (wb_ready), .vrf_we_o, .vrf_waddr_o, .vrf_wdata_o, .vrf_wbe_o,
    .vfu_rsp_valid_o, .vfu_rsp_id_o
  );

endmodule

/* verif/vfu_tb.sv */
/*
  Directed testbench for the vector functional unit.
  Surrounds the DUT with a VRF model, runs one task per behavior and
  checks every destination word against a reference of the ALU rules.
*/
`include "vfu_params.svh"

module vfu_tb import vfu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 10;
  localparam int N_TESTS         = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WAIT_CYCLES     = 150;
  localparam int WORDS           = 128;

  logic            clk;
  logic            rst_n;
  logic            req_valid;
  logic            req_ready;
  vfu_id_t         req_id;
  vfu_op_e         req_op;
  vew_e            req_vsew;
  vl_t             req_vl;
  vl_t             req_vstart;
  logic [4:0]      req_vs1;
  logic [4:0]      req_vs2;
  logic [4:0]      req_vd;
  logic            req_use_vs1;
  logic [31:0]     req_rs1;
  logic [1:0]      vrf_re;
  vaddr_t [1:0]    vrf_raddr;
  logic [1:0]      vrf_rvalid;
  vfu_word_u [1:0] vrf_rdata;
  logic            vrf_we;
  vaddr_t          vrf_waddr;
  vfu_word_u       vrf_wdata;
  vbe_t            vrf_wbe;
  logic            vrf_wvalid;
  logic            rsp_valid;
  logic            rsp_ready;
  vfu_id_t         rsp_id;

  // VRF model, expected contents and response bookkeeping
  vfu_word_u   vrf [WORDS];
  vfu_word_u   exp_vrf [WORDS];
  vfu_id_t     rsp_q [$];
  vfu_id_t     exp_ids [$];
  logic        wr_fire;
  vaddr_t      wr_addr;
  vfu_word_u   wr_data;
  vbe_t        wr_be;
  logic        rsp_fire;
  vfu_id_t     rsp_seen;
  logic        fill_req;
  logic [31:0] fill_salt;
  logic        stall_en;
  logic [31:0] lfsr_q;
  int          n_checks;
  int          n_errors;

  vfu_top vfu_top_inst (
    .clk_i(clk), .rst_n_i(rst_n),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_id_i(req_id),
    .req_op_i(req_op), .req_vsew_i(req_vsew), .req_vl_i(req_vl),
    .req_vstart_i(req_vstart), .req_vs1_i(req_vs1), .req_vs2_i(req_vs2),
    .req_vd_i(req_vd), .req_use_vs1_i(req_use_vs1), .req_rs1_i(req_rs1),
    .vrf_re_o(vrf_re), .vrf_raddr_o(vrf_raddr), .vrf_rvalid_i(vrf_rvalid),
    .vrf_rdata_i(vrf_rdata), .vrf_we_o(vrf_we), .vrf_waddr_o(vrf_waddr),
    .vrf_wdata_o(vrf_wdata), .vrf_wbe_o(vrf_wbe), .vrf_wvalid_i(vrf_wvalid),
    .vfu_rsp_valid_o(rsp_valid), .vfu_rsp_ready_i(rsp_ready), .vfu_rsp_id_o(rsp_id)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // VRF model
  ////////////////////////////////////////

  // A port only returns data while it is requested
  assign vrf_rdata[0] = vrf_re[0] ? vrf[vrf_raddr[0]] : 'x;
  assign vrf_rdata[1] = vrf_re[1] ? vrf[vrf_raddr[1]] : 'x;

  // Handshakes sampled mid-cycle, committed on the next rising edge
  always @(negedge clk) begin
    wr_fire  <= rst_n && vrf_we && vrf_wvalid && (!rsp_valid || rsp_ready);
    wr_addr  <= vrf_waddr;
    wr_data  <= vrf_wdata;
    wr_be    <= vrf_wbe;
    rsp_fire <= rst_n && rsp_valid && rsp_ready && vrf_wvalid;
    rsp_seen <= rsp_id;
  end

  always @(posedge clk) begin
    if (fill_req) begin
      for (int a = 0; a < WORDS; a++) begin
        vrf[a] <= fill_word(a, fill_salt);
      end
    end else if (wr_fire) begin
      for (int k = 0; k < `VFU_WORD_BYTES; k++) begin
        if (wr_be[k]) vrf[wr_addr].b[k] <= wr_data.b[k];
      end
    end
    if (rsp_fire) rsp_q.push_back(rsp_seen);
  end

  ////////////////////////////////////////
  // Stall generator
  ////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // High three cycles in four on average
  function automatic logic ready_draw();
    logic b0;
    logic b1;
    b0 = lfsr_bit();
    b1 = lfsr_bit();
    return b0 | b1;
  endfunction

  initial begin
    lfsr_q     = 32'd32;
    vrf_rvalid = 2'b11;
    vrf_wvalid = 1'b1;
    rsp_ready  = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      if (stall_en) begin
        vrf_rvalid[0] = ready_draw();
        vrf_rvalid[1] = ready_draw();
        vrf_wvalid    = ready_draw();
        rsp_ready     = ready_draw();
      end else begin
        vrf_rvalid = 2'b11;
        vrf_wvalid = 1'b1;
        rsp_ready  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Every word depends on its full address
  function automatic vfu_word_u fill_word(int addr, logic [31:0] salt);
    logic [31:0] a;
    a = 32'(addr);
    return {(a * 32'h9e37_79b9) ^ salt, (a + salt) * 32'h85eb_ca6b};
  endfunction

  function automatic logic [31:0] get_elem(int vreg, int e, int nb);
    logic [31:0] v;
    int          bi;
    v = '0;
    for (int k = 0; k < nb; k++) begin
      bi = e * nb + k;
      v[8*k +: 8] = exp_vrf[vreg * `VFU_WORDS_PER_VREG + bi / 8].b[bi % 8];
    end
    return v;
  endfunction

  task automatic put_elem(input int vreg, input int e, input int nb, input logic [31:0] v);
    int bi;
    for (int k = 0; k < nb; k++) begin
      bi = e * nb + k;
      exp_vrf[vreg * `VFU_WORDS_PER_VREG + bi / 8].b[bi % 8] = v[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] ref_op(vfu_op_e op, logic [31:0] a, logic [31:0] b,
                                         int nb);
    int                 w;
    logic [31:0]        mask;
    logic [31:0]        r;
    logic signed [32:0] sa;
    logic signed [32:0] sb;
    w    = nb * 8;
    mask = (32'h1 << w) - 32'h1;
    a    = a & mask;
    b    = b & mask;
    // Two's complement value of each element
    sa = $signed({1'b0, a}) - (a[w-1] ? (33'sd1 << w) : 33'sd0);
    sb = $signed({1'b0, b}) - (b[w-1] ? (33'sd1 << w) : 33'sd0);
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_MIN:  r = (sa < sb) ? a : b;
      OP_MAX:  r = (sa > sb) ? a : b;
      default: r = a << (b % w);
    endcase
    return r & mask;
  endfunction

  ////////////////////////////////////////
  // Drivers and checks
  ////////////////////////////////////////

  task automatic check_word(input string name, input vfu_word_u got, input vfu_word_u exp);
    n_checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_id(input string name, input vfu_id_t got, input vfu_id_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_flags(input string name, input logic [1:0] got,
                             input logic [1:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  // Nothing in flight: queue open, no reads, no writes, no response
  task automatic check_idle();
    check_flags("req_ready_o", {1'b0, req_ready}, 2'b01);
    check_flags("vrf_re_o", vrf_re, 2'b00);
    check_flags("vrf_we_o", {1'b0, vrf_we}, 2'b00);
    check_flags("vfu_rsp_valid_o", {1'b0, rsp_valid}, 2'b00);
  endtask

  task automatic preload(input logic [31:0] salt);
    for (int a = 0; a < WORDS; a++) begin
      exp_vrf[a] = fill_word(a, salt);
    end
    fill_salt = salt;
    fill_req  = 1'b1;
    @(posedge clk);
    #2;
    fill_req = 1'b0;
  endtask

  task automatic send(input vfu_id_t id, input vfu_op_e op, input vew_e ew, input int vl,
                      input int vstart, input int vs1, input int vs2, input int vd,
                      input logic use_vs1, input logic [31:0] rs1);
    int          nb;
    int          waited;
    logic        accepted;
    logic [31:0] b;
    nb = 1 << ew;
    for (int e = vstart; e < vl; e++) begin
      b = use_vs1 ? get_elem(vs1, e, nb) : rs1;
      put_elem(vd, e, nb, ref_op(op, get_elem(vs2, e, nb), b, nb));
    end
    exp_ids.push_back(id);
    req_id      = id;
    req_op      = op;
    req_vsew    = ew;
    req_vl      = vl_t'(vl);
    req_vstart  = vl_t'(vstart);
    req_vs1     = 5'(vs1);
    req_vs2     = 5'(vs2);
    req_vd      = 5'(vd);
    req_use_vs1 = use_vs1;
    req_rs1     = rs1;
    req_valid   = 1'b1;
    waited      = 0;
    do begin
      @(negedge clk);
      accepted = req_ready;
      @(posedge clk);
      #2;
      waited++;
    end while (!accepted && waited < WAIT_CYCLES);
    req_valid = 1'b0;
    if (!accepted) begin
      $display("request with id %0d was never accepted", id);
      n_errors++;
    end
  endtask

  // Responses must match the send order, one each
  task automatic wait_rsps(input int n);
    int waited;
    waited = 0;
    while (rsp_q.size() < n && waited < WAIT_CYCLES) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (rsp_q.size() < n) begin
      $display("timed out waiting for %0d responses, only %0d came", n, rsp_q.size());
      n_errors++;
    end
    while (rsp_q.size() > 0 && exp_ids.size() > 0) begin
      check_id("vfu_rsp_id_o", rsp_q.pop_front(), exp_ids.pop_front());
    end
    repeat (8) @(posedge clk);
    #2;
    if (rsp_q.size() != 0) begin
      $display("%0d responses arrived that no instruction asked for", rsp_q.size());
      n_errors++;
    end
    check_idle();
    rsp_q.delete();
    exp_ids.delete();
  endtask

  task automatic check_reg(input int vreg);
    int a;
    for (int w = 0; w < `VFU_WORDS_PER_VREG; w++) begin
      a = vreg * `VFU_WORDS_PER_VREG + w;
      check_word($sformatf("vrf[%0d]", a), vrf[a], exp_vrf[a]);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_add_sub();
    int e0;
    e0 = n_errors;
    preload(32'h0000_1111);
    send(2'd0, OP_ADD, EW_32, 8, 0, 1, 2, 3, 1'b1, '0);
    send(2'd1, OP_SUB, EW_32, 8, 0, 1, 2, 4, 1'b1, '0);
    wait_rsps(2);
    check_reg(3);
    check_reg(4);
    $display("add_sub_ew32        %0d errors", n_errors - e0);
  endtask

  task automatic test_logic_scalar();
    int e0;
    e0 = n_errors;
    preload(32'h5a5a_0f0f);
    send(2'd2, OP_AND, EW_8, 32, 0, 0, 5, 6, 1'b0, 32'h1234_5696);
    send(2'd3, OP_OR, EW_8, 32, 0, 0, 5, 7, 1'b0, 32'hffff_ff41);
    send(2'd0, OP_XOR, EW_8, 32, 0, 0, 5, 8, 1'b0, 32'h0000_00c3);
    wait_rsps(3);
    check_reg(6);
    check_reg(7);
    check_reg(8);
    $display("logic_scalar_ew8    %0d errors", n_errors - e0);
  endtask

  // Fill pattern puts a set top bit in about half the halfwords
  task automatic test_minmax_sll();
    int e0;
    e0 = n_errors;
    preload(32'hdead_7001);
    send(2'd1, OP_MIN, EW_16, 16, 0, 9, 10, 11, 1'b1, '0);
    send(2'd2, OP_MAX, EW_16, 16, 0, 9, 10, 12, 1'b1, '0);
    send(2'd3, OP_SLL, EW_16, 16, 0, 9, 10, 13, 1'b1, '0);
    wait_rsps(3);
    check_reg(11);
    check_reg(12);
    check_reg(13);
    $display("minmax_sll_ew16     %0d errors", n_errors - e0);
  endtask

  task automatic test_vstart_vl();
    int e0;
    e0 = n_errors;
    preload(32'h0bad_cafe);
    send(2'd3, OP_ADD, EW_16, 6, 3, 14, 15, 16, 1'b1, '0);
    wait_rsps(1);
    check_reg(16);
    $display("vstart_vl_ew16      %0d errors", n_errors - e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = n_errors;
    preload(32'h7777_1234);
    stall_en = 1'b1;
    send(2'd1, OP_XOR, EW_32, 8, 0, 17, 18, 19, 1'b1, '0);
    send(2'd2, OP_SLL, EW_8, 32, 0, 0, 20, 21, 1'b0, 32'h0000_0005);
    send(2'd3, OP_MAX, EW_16, 16, 0, 22, 23, 24, 1'b1, '0);
    wait_rsps(3);
    stall_en = 1'b0;
    check_reg(19);
    check_reg(21);
    check_reg(24);
    $display("backpressure        %0d errors", n_errors - e0);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_id      = '0;
    req_op      = OP_ADD;
    req_vsew    = EW_8;
    req_vl      = '0;
    req_vstart  = '0;
    req_vs1     = '0;
    req_vs2     = '0;
    req_vd      = '0;
    req_use_vs1 = 1'b0;
    req_rs1     = '0;
    wr_fire     = 1'b0;
    rsp_fire    = 1'b0;
    fill_req    = 1'b0;
    fill_salt   = '0;
    stall_en    = 1'b0;
    n_checks    = 0;
    n_errors    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_idle();
    test_add_sub();
    test_logic_scalar();
    test_minmax_sll();
    test_vstart_vl();
    test_backpressure();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized for every test running its full cycle budget
  initial begin
    #((RESET_CYCLES + N_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("test failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
design/vfu_pkg.sv
design/vfu_req_queue.sv
design/vfu_sequencer.sv
design/vfu_operand_stage.sv
design/vfu_alu.sv
design/vfu_writeback.sv
design/vfu_top.sv
verif/vfu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the VFU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module vfu_tb -o vfu_sim
./obj_dir/vfu_sim | tee sim.log

if grep -q "^test passed$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
